//--- hw/ex_pkg.sv
//--------------------------------------------------------------------
// execute stage shared definitions
// register index, funct3 and size vectors, the result zone, the ALU
// operation codes, the stream epoch and the branch compare codes
//--------------------------------------------------------------------
`default_nettype none

package ex_pkg;

    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] funct3_t;
    // size counted in half-words
    typedef logic [1:0] ins_size_t;

    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // epoch of the instruction stream
    typedef enum logic {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_t;

    // branch compare codes, same encoding as the funct3 field
    localparam funct3_t CMP_EQ  = 3'b000;
    localparam funct3_t CMP_NE  = 3'b001;
    localparam funct3_t CMP_LT  = 3'b100;
    localparam funct3_t CMP_GE  = 3'b101;
    localparam funct3_t CMP_LTU = 3'b110;
    localparam funct3_t CMP_GEU = 3'b111;

endpackage

`default_nettype wire

//--- hw/ex_issue_reg.sv
//--------------------------------------------------------------------
// execute stage issue register
// holds the decoded instruction for its commit cycle, turns the
// result zone into one-hot write flags and forms the link address
//--------------------------------------------------------------------
`default_nettype none

interface ex_issue_if #(
    parameter int XLEN = 32
);
    import ex_pkg::*;

    logic            valid;
    logic            jump;
    logic            cond;
    logic            link;
    logic            lq_wr;
    logic            sq_wr;
    logic            regd_wr;
    logic [XLEN-1:0] pc_inc;
    logic [XLEN-1:0] regs2_data;
    reg_addr_t       regd_addr;
    funct3_t         funct3;

    modport issue (
        output valid, jump, cond, link, lq_wr, sq_wr, regd_wr,
        output pc_inc, regs2_data, regd_addr, funct3
    );

    modport commit (
        input valid, jump, cond, link, lq_wr, sq_wr, regd_wr,
        input pc_inc, regs2_data, regd_addr, funct3
    );
endinterface

module ex_issue_reg #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              resetb_i,
    input  logic              stage_en_i,
    input  logic              ids_valid_i,
    input  logic              ids_jump_i,
    input  logic              ids_cond_i,
    input  logic              ids_link_i,
    input  ex_pkg::zone_t     ids_zone_i,
    input  ex_pkg::ins_size_t ids_ins_size_i,
    input  logic [XLEN-1:0]   ids_pc_i,
    input  logic [XLEN-1:0]   ids_regs2_data_i,
    input  ex_pkg::reg_addr_t ids_regd_addr_i,
    input  ex_pkg::funct3_t   ids_funct3_i,
    ex_issue_if.issue         iss
);
    import ex_pkg::*;

    //----------------------------------------------------------------
    // control flags
    //----------------------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            iss.valid   <= 1'b0;
            iss.jump    <= 1'b0;
            iss.cond    <= 1'b0;
            iss.link    <= 1'b0;
            iss.lq_wr   <= 1'b0;
            iss.sq_wr   <= 1'b0;
            iss.regd_wr <= 1'b0;
        end else if (stage_en_i) begin
            iss.valid <= ids_valid_i;
            iss.jump  <= ids_jump_i;
            iss.cond  <= ids_cond_i;
            iss.link  <= ids_link_i;
            // zone none leaves all three flags low
            iss.lq_wr   <= (ids_zone_i == ZONE_LOADQ);
            iss.sq_wr   <= (ids_zone_i == ZONE_STOREQ);
            iss.regd_wr <= (ids_zone_i == ZONE_REGFILE);
        end
    end

    //----------------------------------------------------------------
    // payload
    //----------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            // link address is pc plus size in bytes
            iss.pc_inc     <= ids_pc_i + {{(XLEN-3){1'b0}}, ids_ins_size_i, 1'b0};
            iss.regs2_data <= ids_regs2_data_i;
            iss.regd_addr  <= ids_regd_addr_i;
            iss.funct3     <= ids_funct3_i;
        end
    end

    // a valid capture leaves known write flags
    a_zone_known : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        (stage_en_i && ids_valid_i) |=> !$isunknown({iss.lq_wr, iss.sq_wr, iss.regd_wr})
    ) else $error("zone unknown on a valid instruction");

endmodule

`default_nettype wire

//--- hw/ex_alu.sv
//--------------------------------------------------------------------
// execute stage ALU
// computes the operation and the branch compare from the decoder
// operands and registers both while the stage is enabled
//--------------------------------------------------------------------
`default_nettype none

module ex_alu #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            resetb_i,
    input  logic            stage_en_i,
    input  ex_pkg::alu_op_t op_i,
    input  logic [XLEN-1:0] op_left_i,
    input  logic [XLEN-1:0] op_right_i,
    input  logic [XLEN-1:0] cmp_left_i,
    input  logic [XLEN-1:0] cmp_right_i,
    input  ex_pkg::funct3_t cmp_code_i,
    output logic [XLEN-1:0] result_o,
    output logic            cmp_o
);
    import ex_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] result_d;
    logic            cmp_d;
    logic            lt_s;
    logic            lt_u;
    logic            cmp_lt_s;
    logic            cmp_lt_u;
    logic            cmp_eq;

    // shifts use only the low bits of the right operand
    assign shamt = op_right_i[SHW-1:0];
    assign lt_s  = $signed(op_left_i) < $signed(op_right_i);
    assign lt_u  = op_left_i < op_right_i;

    //----------------------------------------------------------------
    // operation
    //----------------------------------------------------------------
    always_comb begin
        case (op_i)
            ALU_ADD:  result_d = op_left_i + op_right_i;
            ALU_SUB:  result_d = op_left_i - op_right_i;
            ALU_AND:  result_d = op_left_i & op_right_i;
            ALU_OR:   result_d = op_left_i | op_right_i;
            ALU_XOR:  result_d = op_left_i ^ op_right_i;
            ALU_SLL:  result_d = op_left_i << shamt;
            ALU_SRL:  result_d = op_left_i >> shamt;
            ALU_SRA:  result_d = $signed(op_left_i) >>> shamt;
            ALU_SLT:  result_d = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_d = {{(XLEN-1){1'b0}}, lt_u};
            default:  result_d = '0;
        endcase
    end

    //----------------------------------------------------------------
    // branch compare
    //----------------------------------------------------------------
    assign cmp_eq   = cmp_left_i == cmp_right_i;
    assign cmp_lt_s = $signed(cmp_left_i) < $signed(cmp_right_i);
    assign cmp_lt_u = cmp_left_i < cmp_right_i;

    always_comb begin
        case (cmp_code_i)
            CMP_EQ:  cmp_d = cmp_eq;
            CMP_NE:  cmp_d = !cmp_eq;
            CMP_LT:  cmp_d = cmp_lt_s;
            CMP_GE:  cmp_d = !cmp_lt_s;
            CMP_LTU: cmp_d = cmp_lt_u;
            CMP_GEU: cmp_d = !cmp_lt_u;
            // 010 and 011 are not branch codes
            default: cmp_d = 1'b0;
        endcase
    end

    //----------------------------------------------------------------
    // output registers
    //----------------------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            cmp_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_o <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_o <= result_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/ex_commit.sv
//--------------------------------------------------------------------
// execute stage commit
// tracks the stream epoch after a redirect, qualifies the held
// instruction, stalls on a full load/store queue and drives the
// write-back, redirect and queue strobes
//--------------------------------------------------------------------
`default_nettype none

module ex_commit #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              resetb_i,
    ex_issue_if.commit        iss,
    input  logic [XLEN-1:0]   alu_result_i,
    input  logic              cmp_i,
    input  logic              ids_valid_i,
    input  ex_pkg::sofid_t    ids_sofid_i,
    input  logic              lsq_full_i,
    output logic              stage_en_o,
    output logic              ids_stall_o,
    output logic              pfu_jump_o,
    output logic [XLEN-1:0]   pfu_jump_addr_o,
    output logic              ids_regd_cncl_load_o,
    output logic              ids_regd_wr_o,
    output ex_pkg::reg_addr_t ids_regd_addr_o,
    output logic [XLEN-1:0]   ids_regd_data_o,
    output logic              lsq_lq_wr_o,
    output logic              lsq_sq_wr_o,
    output ex_pkg::funct3_t   lsq_funct3_o,
    output ex_pkg::reg_addr_t lsq_regd_addr_o,
    output logic [XLEN-1:0]   lsq_regs2_data_o,
    output logic [XLEN-1:0]   lsq_addr_o
);
    import ex_pkg::*;

    sofid_t sofid_q;
    logic   ex_valid;
    logic   execute_commit;
    logic   jump;
    logic   stall;
    logic   stage_en;

    //----------------------------------------------------------------
    // qualification
    //----------------------------------------------------------------
    // wrong-path instructions are dropped while the epoch is jump
    assign ex_valid       = iss.valid && (sofid_q == SOFID_RUN);
    assign execute_commit = ex_valid && (!iss.cond || cmp_i);
    assign jump           = execute_commit && iss.jump;

    //----------------------------------------------------------------
    // stall control
    //----------------------------------------------------------------
    assign stall       = execute_commit && lsq_full_i && (iss.lq_wr || iss.sq_wr);
    assign stage_en    = !stall;
    assign stage_en_o  = stage_en;
    assign ids_stall_o = stall;

    //----------------------------------------------------------------
    // epoch FSM
    //----------------------------------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            sofid_q <= SOFID_RUN;
        end else if (stage_en) begin
            if (jump) begin
                sofid_q <= SOFID_JUMP;
            end else if (ids_valid_i && ids_sofid_i == SOFID_JUMP) begin
                // first instruction from the new target
                sofid_q <= SOFID_RUN;
            end
        end
    end

    //----------------------------------------------------------------
    // strobes and data
    //----------------------------------------------------------------
    assign pfu_jump_o      = stage_en && jump;
    assign pfu_jump_addr_o = alu_result_i;

    // loads that are dropped still tell the decoder to release rd
    assign ids_regd_cncl_load_o = stage_en && !execute_commit && iss.valid && iss.lq_wr;
    assign ids_regd_wr_o        = stage_en && execute_commit && iss.regd_wr;
    assign ids_regd_addr_o      = iss.regd_addr;
    assign ids_regd_data_o      = iss.link ? iss.pc_inc : alu_result_i;

    assign lsq_lq_wr_o      = stage_en && execute_commit && iss.lq_wr;
    assign lsq_sq_wr_o      = stage_en && execute_commit && iss.sq_wr;
    assign lsq_funct3_o     = iss.funct3;
    assign lsq_regd_addr_o  = iss.regd_addr;
    assign lsq_regs2_data_o = iss.regs2_data;
    assign lsq_addr_o       = alu_result_i;

    //----------------------------------------------------------------
    // checks
    //----------------------------------------------------------------
    a_lsq_excl : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        !(lsq_lq_wr_o && lsq_sq_wr_o)
    ) else $error("load and store queue written together");

    // the held instruction stays until its queue write goes out
    a_stall_release : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        ids_stall_o |=> (ids_stall_o || lsq_lq_wr_o || lsq_sq_wr_o)
    ) else $error("stalled load or store left without its queue write");

endmodule

`default_nettype wire

//--- hw/ex_stage_top.sv
//--------------------------------------------------------------------
// execute stage top level
// issue register, ALU and commit logic behind the plain decoder,
// fetch and load/store queue ports
//--------------------------------------------------------------------
`default_nettype none

module ex_stage_top #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              resetb_i,
    // decoder side
    input  logic              ids_valid_i,
    input  ex_pkg::sofid_t    ids_sofid_i,
    input  ex_pkg::ins_size_t ids_ins_size_i,
    input  logic              ids_jump_i,
    input  logic              ids_cond_i,
    input  ex_pkg::zone_t     ids_zone_i,
    input  logic              ids_link_i,
    input  logic [XLEN-1:0]   ids_pc_i,
    input  ex_pkg::alu_op_t   ids_alu_op_i,
    input  logic [XLEN-1:0]   ids_operand_left_i,
    input  logic [XLEN-1:0]   ids_operand_right_i,
    input  logic [XLEN-1:0]   ids_cmp_right_i,
    input  logic [XLEN-1:0]   ids_regs1_data_i,
    input  logic [XLEN-1:0]   ids_regs2_data_i,
    input  ex_pkg::reg_addr_t ids_regd_addr_i,
    input  ex_pkg::funct3_t   ids_funct3_i,
    output logic              ids_stall_o,
    // write-back
    output logic              ids_regd_cncl_load_o,
    output logic              ids_regd_wr_o,
    output ex_pkg::reg_addr_t ids_regd_addr_o,
    output logic [XLEN-1:0]   ids_regd_data_o,
    // fetch redirect
    output logic              pfu_jump_o,
    output logic [XLEN-1:0]   pfu_jump_addr_o,
    // load/store queue
    input  logic              lsq_full_i,
    output logic              lsq_lq_wr_o,
    output logic              lsq_sq_wr_o,
    output ex_pkg::funct3_t   lsq_funct3_o,
    output ex_pkg::reg_addr_t lsq_regd_addr_o,
    output logic [XLEN-1:0]   lsq_regs2_data_o,
    output logic [XLEN-1:0]   lsq_addr_o
);

    logic            stage_en;
    logic [XLEN-1:0] alu_result;
    logic            cmp_result;

    ex_issue_if #(.XLEN(XLEN)) u_issue_if ();

    ex_issue_reg #(.XLEN(XLEN)) u_issue_reg (
        .clk_i            (clk_i),
        .resetb_i         (resetb_i),
        .stage_en_i       (stage_en),
        .ids_valid_i      (ids_valid_i),
        .ids_jump_i       (ids_jump_i),
        .ids_cond_i       (ids_cond_i),
        .ids_link_i       (ids_link_i),
        .ids_zone_i       (ids_zone_i),
        .ids_ins_size_i   (ids_ins_size_i),
        .ids_pc_i         (ids_pc_i),
        .ids_regs2_data_i (ids_regs2_data_i),
        .ids_regd_addr_i  (ids_regd_addr_i),
        .ids_funct3_i     (ids_funct3_i),
        .iss              (u_issue_if.issue)
    );

    // compare operands are rs1 and the compare right operand
    ex_alu #(.XLEN(XLEN)) u_alu (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .stage_en_i  (stage_en),
        .op_i        (ids_alu_op_i),
        .op_left_i   (ids_operand_left_i),
        .op_right_i  (ids_operand_right_i),
        .cmp_left_i  (ids_regs1_data_i),
        .cmp_right_i (ids_cmp_right_i),
        .cmp_code_i  (ids_funct3_i),
        .result_o    (alu_result),
        .cmp_o       (cmp_result)
    );

    ex_commit #(.XLEN(XLEN)) u_commit (
        .clk_i                (clk_i),
        .resetb_i             (resetb_i),
        .iss                  (u_issue_if.commit),
        .alu_result_i         (alu_result),
        .cmp_i                (cmp_result),
        .ids_valid_i          (ids_valid_i),
        .ids_sofid_i          (ids_sofid_i),
        .lsq_full_i           (lsq_full_i),
        .stage_en_o           (stage_en),
        .ids_stall_o          (ids_stall_o),
        .pfu_jump_o           (pfu_jump_o),
        .pfu_jump_addr_o      (pfu_jump_addr_o),
        .ids_regd_cncl_load_o (ids_regd_cncl_load_o),
        .ids_regd_wr_o        (ids_regd_wr_o),
        .ids_regd_addr_o      (ids_regd_addr_o),
        .ids_regd_data_o      (ids_regd_data_o),
        .lsq_lq_wr_o          (lsq_lq_wr_o),
        .lsq_sq_wr_o          (lsq_sq_wr_o),
        .lsq_funct3_o         (lsq_funct3_o),
        .lsq_regd_addr_o      (lsq_regd_addr_o),
        .lsq_regs2_data_o     (lsq_regs2_data_o),
        .lsq_addr_o           (lsq_addr_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ex_checks.sv
//----------------------------------------------------------------------
// execute stage reference model and checks
// models the one instruction held for commit and its stream epoch,
// and compares the commit strobes and data with the model
//----------------------------------------------------------------------
`default_nettype none

module tb_ex_checks #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              resetb_i,
    // decoder side of the DUT
    input  logic              ids_valid_i, ids_jump_i, ids_cond_i, ids_link_i,
    input  ex_pkg::sofid_t    ids_sofid_i,
    input  ex_pkg::ins_size_t ids_ins_size_i,
    input  ex_pkg::zone_t     ids_zone_i,
    input  ex_pkg::alu_op_t   ids_alu_op_i,
    input  logic [XLEN-1:0]   ids_pc_i, ids_operand_left_i, ids_operand_right_i,
    input  logic [XLEN-1:0]   ids_cmp_right_i, ids_regs1_data_i, ids_regs2_data_i,
    input  ex_pkg::reg_addr_t ids_regd_addr_i,
    input  ex_pkg::funct3_t   ids_funct3_i,
    input  logic              lsq_full_i,
    // DUT outputs, observed only
    input  logic              ids_stall_o, ids_regd_cncl_load_o, ids_regd_wr_o,
    input  logic              pfu_jump_o, lsq_lq_wr_o, lsq_sq_wr_o,
    input  ex_pkg::reg_addr_t ids_regd_addr_o, lsq_regd_addr_o,
    input  ex_pkg::funct3_t   lsq_funct3_o,
    input  logic [XLEN-1:0]   ids_regd_data_o, pfu_jump_addr_o,
    input  logic [XLEN-1:0]   lsq_regs2_data_o, lsq_addr_o,
    output logic              fail_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    logic            failed = 1'b0;
    logic            m_valid, m_jump, m_cond, m_link, m_cmp;
    zone_t           m_zone;
    sofid_t          m_epoch;
    funct3_t         m_funct3;
    reg_addr_t       m_regd;
    logic [XLEN-1:0] m_alu, m_link_addr, m_regs2;
    logic            commit_ok, is_lsq, advance;
    logic            exp_stall, exp_jump, exp_wr, exp_cncl, exp_lq, exp_sq;

    assign fail_o = failed;

    function automatic logic [XLEN-1:0] alu_ref(alu_op_t op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        int unsigned sh;
        sh = 32'(b % XLEN);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $signed(a) >>> sh;
            ALU_SLT:  return XLEN'($signed(a) < $signed(b));
            ALU_SLTU: return XLEN'(a < b);
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(funct3_t code, logic [XLEN-1:0] a,
                                          logic [XLEN-1:0] b);
        case (code)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return $signed(a) < $signed(b);
            CMP_GE:  return $signed(a) >= $signed(b);
            CMP_LTU: return a < b;
            CMP_GEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        failed = 1'b1;
    endtask

    //------------------------------------------------------------------
    // expected commit of the held instruction
    //------------------------------------------------------------------
    assign commit_ok = m_valid && (m_epoch == SOFID_RUN) && (!m_cond || m_cmp);
    assign is_lsq    = (m_zone == ZONE_LOADQ) || (m_zone == ZONE_STOREQ);
    assign exp_stall = commit_ok && lsq_full_i && is_lsq;
    assign advance   = !exp_stall;
    assign exp_jump  = advance && commit_ok && m_jump;
    assign exp_wr    = advance && commit_ok && (m_zone == ZONE_REGFILE);
    // a dropped load still releases its destination
    assign exp_cncl  = advance && !commit_ok && m_valid && (m_zone == ZONE_LOADQ);
    assign exp_lq    = advance && commit_ok && (m_zone == ZONE_LOADQ);
    assign exp_sq    = advance && commit_ok && (m_zone == ZONE_STOREQ);

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            m_valid <= 1'b0;
            m_epoch <= SOFID_RUN;
        end else if (advance) begin
            m_valid     <= ids_valid_i;
            m_jump      <= ids_jump_i;
            m_cond      <= ids_cond_i;
            m_link      <= ids_link_i;
            m_zone      <= ids_zone_i;
            m_funct3    <= ids_funct3_i;
            m_regd      <= ids_regd_addr_i;
            m_regs2     <= ids_regs2_data_i;
            m_link_addr <= ids_pc_i + (XLEN'(ids_ins_size_i) << 1);
            m_alu <= alu_ref(ids_alu_op_i, ids_operand_left_i, ids_operand_right_i);
            m_cmp <= branch_taken(ids_funct3_i, ids_regs1_data_i, ids_cmp_right_i);
            if (exp_jump) begin
                m_epoch <= SOFID_JUMP;
            end else if (ids_valid_i && ids_sofid_i == SOFID_JUMP) begin
                m_epoch <= SOFID_RUN;
            end
        end
    end

    //------------------------------------------------------------------
    // checks
    //------------------------------------------------------------------
    a_stall : assert property (@(posedge clk_i) disable iff (!resetb_i)
        ids_stall_o == exp_stall)
        else report_error("ids_stall_o differs from the model");

    a_strobes : assert property (@(posedge clk_i) disable iff (!resetb_i)
        {pfu_jump_o, ids_regd_wr_o, ids_regd_cncl_load_o, lsq_lq_wr_o, lsq_sq_wr_o} ==
        {exp_jump, exp_wr, exp_cncl, exp_lq, exp_sq})
        else report_error("commit strobes differ from the model");

    a_regd : assert property (@(posedge clk_i) disable iff (!resetb_i)
        exp_wr |-> (ids_regd_addr_o == m_regd) &&
                   (ids_regd_data_o == (m_link ? m_link_addr : m_alu)))
        else report_error("register write address or data wrong");

    a_jump_addr : assert property (@(posedge clk_i) disable iff (!resetb_i)
        exp_jump |-> pfu_jump_addr_o == m_alu)
        else report_error("jump address wrong");

    a_lsq : assert property (@(posedge clk_i) disable iff (!resetb_i)
        (exp_lq || exp_sq) |-> (lsq_addr_o == m_alu) && (lsq_regs2_data_o == m_regs2) &&
                               (lsq_funct3_o == m_funct3) && (lsq_regd_addr_o == m_regd))
        else report_error("load/store queue fields wrong");

endmodule

`default_nettype wire

//--- testbench/tb_ex_stage.sv
//----------------------------------------------------------------------
// execute stage testbench
// random decoder stream with load/store queue full bursts, driven on
// falling edges and checked by the reference model in tb_ex_checks
//----------------------------------------------------------------------
`default_nettype none

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import ex_pkg::*;

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_INSTR  = 2000;
    // instruction count plus margin for stalls
    localparam int MAX_CYCLES = 3000;

    logic              clk_i, resetb_i;
    logic              ids_valid_i, ids_jump_i, ids_cond_i, ids_link_i;
    sofid_t            ids_sofid_i;
    ins_size_t         ids_ins_size_i;
    zone_t             ids_zone_i;
    alu_op_t           ids_alu_op_i;
    logic [XLEN-1:0]   ids_pc_i, ids_operand_left_i, ids_operand_right_i;
    logic [XLEN-1:0]   ids_cmp_right_i, ids_regs1_data_i, ids_regs2_data_i;
    reg_addr_t         ids_regd_addr_i, ids_regd_addr_o, lsq_regd_addr_o;
    funct3_t           ids_funct3_i, lsq_funct3_o;
    logic              lsq_full_i;
    logic              ids_stall_o, ids_regd_cncl_load_o, ids_regd_wr_o;
    logic              pfu_jump_o, lsq_lq_wr_o, lsq_sq_wr_o;
    logic [XLEN-1:0]   ids_regd_data_o, pfu_jump_addr_o, lsq_regs2_data_o, lsq_addr_o;
    logic              check_failed;

    int   seed = 32'h1e73_112c;
    int   cycle_count = 0;
    int   issued = 0;
    int   full_left = 0;
    logic holding = 1'b0;
    logic jump_seen = 1'b0;

    ex_stage_top #(.XLEN(XLEN)) u_ex_stage_top (.*);

    tb_ex_checks #(.XLEN(XLEN)) u_checks (.*, .fail_o(check_failed));

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [XLEN-1:0] rand_word();
        return XLEN'($unsigned($random(seed)));
    endfunction

    task automatic init_inputs();
        resetb_i            = 1'b0;
        ids_valid_i         = 1'b0;
        ids_jump_i          = 1'b0;
        ids_cond_i          = 1'b0;
        ids_link_i          = 1'b0;
        ids_sofid_i         = SOFID_RUN;
        ids_ins_size_i      = '0;
        ids_zone_i          = ZONE_NONE;
        ids_alu_op_i        = ALU_ADD;
        ids_pc_i            = '0;
        ids_operand_left_i  = '0;
        ids_operand_right_i = '0;
        ids_cmp_right_i     = '0;
        ids_regs1_data_i    = '0;
        ids_regs2_data_i    = '0;
        ids_regd_addr_i     = '0;
        ids_funct3_i        = '0;
        lsq_full_i          = 1'b0;
    endtask

    // queue full in short random bursts
    task automatic drive_full();
        if (full_left > 0) begin
            lsq_full_i = 1'b1;
            full_left--;
        end else begin
            lsq_full_i = 1'b0;
            if (($random(seed) & 15) == 0) begin
                full_left = 1 + ($random(seed) & 3);
            end
        end
    endtask

    // kinds: 0-2 alu, 3 load, 4 store, 5 branch, 6 jump and link, 7 mixed
    task automatic drive_instr();
        int kind;
        kind = $random(seed) & 7;
        // first instruction after a redirect carries the new epoch
        ids_valid_i = jump_seen || (($random(seed) & 7) != 0);
        ids_sofid_i = jump_seen ? SOFID_JUMP : SOFID_RUN;
        jump_seen   = 1'b0;
        ids_jump_i  = (kind == 5) || (kind == 6);
        ids_cond_i  = (kind == 5);
        ids_link_i  = (kind == 6) || ((kind == 7) && (($random(seed) & 1) != 0));
        case (kind)
            3:       ids_zone_i = ZONE_LOADQ;
            4:       ids_zone_i = ZONE_STOREQ;
            5:       ids_zone_i = ZONE_NONE;
            7:       ids_zone_i = zone_t'($random(seed) & 3);
            default: ids_zone_i = ZONE_REGFILE;
        endcase
        ids_alu_op_i        = alu_op_t'($unsigned($random(seed)) % 10);
        ids_ins_size_i      = ins_size_t'($random(seed));
        ids_pc_i            = rand_word() & ~XLEN'(1);
        ids_operand_left_i  = rand_word();
        ids_operand_right_i = (($random(seed) & 1) != 0) ? (rand_word() & XLEN'(63))
                                                          : rand_word();
        ids_regs1_data_i    = rand_word();
        ids_cmp_right_i     = (($random(seed) & 3) == 0) ? ids_regs1_data_i : rand_word();
        ids_regs2_data_i    = rand_word();
        ids_regd_addr_i     = reg_addr_t'($random(seed));
        ids_funct3_i        = funct3_t'($random(seed));
    endtask

    //------------------------------------------------------------------
    // run limit and failure stop
    //------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no end of the run after %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    always @(posedge check_failed) begin
        $display("Simulation finished: FAIL");
        $fatal(1, "check failed");
    end

    //------------------------------------------------------------------
    // stimulus
    //------------------------------------------------------------------
    initial begin
        init_inputs();
        repeat (2) @(negedge clk_i);
        resetb_i = 1'b1;
        while (issued < NUM_INSTR) begin
            @(negedge clk_i);
            drive_full();
            if (!holding) begin
                drive_instr();
            end
            // outputs settle well ahead of the capture edge
            #(CLK_PERIOD / 4);
            holding = ids_stall_o;
            if (!holding) begin
                issued++;
            end
            if (pfu_jump_o) begin
                jump_seen = 1'b1;
            end
        end
        repeat (3) @(negedge clk_i);
        if (check_failed) begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
hw/ex_pkg.sv
hw/ex_issue_reg.sv
hw/ex_alu.sv
hw/ex_commit.sv
hw/ex_stage_top.sv
testbench/tb_ex_checks.sv
testbench/tb_ex_stage.sv

//--- Makefile
# Verilator build for the execute stage

VERILATOR ?= verilator
TB_TOP    ?= tb_ex_stage
RTL_TOP   ?= ex_stage_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
RTL_SRCS  ?= hw/ex_pkg.sv hw/ex_issue_reg.sv hw/ex_alu.sv hw/ex_commit.sv hw/ex_stage_top.sv
VFLAGS    ?= --assert --timescale $(TIMESCALE)
PASS_MSG  := Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
